//--- logic/arithPkg.sv
////////////////////////////////////////
// Shared types for the arithmetic unit
// Opcode, datapath step and byte-select codes
////////////////////////////////////////

package arithPkg;

  // Width of the byte-wide data input and readback output
  localparam int ByteWidth = 8;

  ////////////////////////////////////////
  // Operation codes
  ////////////////////////////////////////

  // Load shares the field with the arithmetic ops and means no arithmetic
  typedef enum logic [1:0] {
    opLoad = 2'b00,
    opAdd  = 2'b01,
    opSub  = 2'b10,
    opMul  = 2'b11
  } opT;

  // What the shared datapath does this cycle
  typedef enum logic [1:0] {
    stepIdle = 2'b00,
    stepAdd  = 2'b01,
    stepSub  = 2'b10,
    stepMul  = 2'b11
  } stepT;

  ////////////////////////////////////////
  // Byte selection
  ////////////////////////////////////////

  // Same coding for loads and for readback
  typedef enum logic [1:0] {
    selALow  = 2'b00,
    selAHigh = 2'b01,
    selBLow  = 2'b10,
    selBHigh = 2'b11
  } byteSelT;

endpackage

//--- logic/arithSequencer.sv
////////////////////////////////////////
// Operation sequencer
// Op decode, multiply step count, busy and done
////////////////////////////////////////

`timescale 1ns/1ns

module arithSequencer #(
  parameter int WordWidth = 16
) (
  input  logic              CLK,
  input  logic              RST,
  input  logic              opStart,
  input  arithPkg::opT      op,
  output arithPkg::stepT    step,
  output logic              busy,
  output logic              done
);

  // One shift-and-add step per bit of the low half
  localparam int MulSteps = WordWidth / 2;
  localparam int CntW     = $clog2(MulSteps + 1);

  logic [CntW-1:0] stepCnt;
  logic            accept;
  logic            mulStart;
  logic            singleDone;
  logic            lastStep;

  // New ops only taken while idle
  assign accept     = opStart && !busy;
  assign mulStart   = accept && (op == arithPkg::opMul);
  assign singleDone = accept && ((op == arithPkg::opAdd) || (op == arithPkg::opSub));
  assign lastStep   = busy && (stepCnt == CntW'(1));

  ////////////////////////////////////////
  // Step decode
  ////////////////////////////////////////

  always_comb
  begin
    step = arithPkg::stepIdle;
    if (busy)
    begin
      step = arithPkg::stepMul;
    end
    else if (opStart)
    begin
      case (op)
        arithPkg::opAdd: step = arithPkg::stepAdd;
        arithPkg::opSub: step = arithPkg::stepSub;
        // Start cycle where the datapath clears the upper half of B
        arithPkg::opMul: step = arithPkg::stepMul;
        default:         step = arithPkg::stepIdle;
      endcase
    end
  end

  ////////////////////////////////////////
  // Busy, counter and done pulse
  ////////////////////////////////////////

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      busy    <= 1'b0;
      done    <= 1'b0;
      stepCnt <= '0;
    end
    else
    begin
      done <= singleDone || lastStep;
      if (mulStart)
      begin
        busy    <= 1'b1;
        stepCnt <= CntW'(MulSteps);
      end
      else if (busy)
      begin
        stepCnt <= stepCnt - CntW'(1);
        if (lastStep)
          busy <= 1'b0;
      end
    end
  end

endmodule

//--- logic/operandRegs.sv
////////////////////////////////////////
// Operand registers A and B
// Byte loads, write-back, multiply shift, readback
////////////////////////////////////////

`timescale 1ns/1ns

module operandRegs #(
  parameter int WordWidth = 16
) (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          loadEn,
  input  arithPkg::byteSelT             byteSel,
  input  logic [arithPkg::ByteWidth-1:0] dataIn,
  input  arithPkg::byteSelT             readSel,
  input  arithPkg::stepT                step,
  input  logic [WordWidth-1:0]          sum,
  input  logic                          sumCarry,
  input  logic                          busy,
  output logic [WordWidth-1:0]          regA,
  output logic [WordWidth-1:0]          regB,
  output logic [arithPkg::ByteWidth-1:0] dataOut
);

  localparam int Half = WordWidth / 2;
  localparam int BW   = arithPkg::ByteWidth;

  logic             loadOk;
  logic [Half-1:0]  upperNext;
  logic             topBit;

  assign loadOk = loadEn && !busy;

  // Conditional add on the multiplier bit, then shift right
  assign upperNext = regB[0] ? sum[Half-1:0] : regB[WordWidth-1:Half];
  assign topBit    = regB[0] & sumCarry;

  ////////////////////////////////////////
  // Register A
  ////////////////////////////////////////

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      regA <= '0;
    else if (loadOk && (byteSel == arithPkg::selALow))
      regA[BW-1:0] <= dataIn;
    else if (loadOk && (byteSel == arithPkg::selAHigh))
      regA[2*BW-1:BW] <= dataIn;
  end

  ////////////////////////////////////////
  // Register B
  ////////////////////////////////////////

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      regB <= '0;
    end
    else
    begin
      case (step)
        arithPkg::stepAdd,
        arithPkg::stepSub:
          regB <= sum;
        arithPkg::stepMul:
          if (!busy)
            // Multiply start clears the partial product half
            regB[WordWidth-1:Half] <= '0;
          else
            regB <= {topBit, upperNext, regB[Half-1:1]};
        default:
          if (loadOk && (byteSel == arithPkg::selBLow))
            regB[BW-1:0] <= dataIn;
          else if (loadOk && (byteSel == arithPkg::selBHigh))
            regB[2*BW-1:BW] <= dataIn;
      endcase
    end
  end

  // Readback mux
  always_comb
  begin
    case (readSel)
      arithPkg::selALow:  dataOut = regA[BW-1:0];
      arithPkg::selAHigh: dataOut = regA[2*BW-1:BW];
      arithPkg::selBLow:  dataOut = regB[BW-1:0];
      default:            dataOut = regB[2*BW-1:BW];
    endcase
  end

endmodule

//--- logic/accumulateUnit.sv
////////////////////////////////////////
// Shared adder with operand select and carry flag
////////////////////////////////////////

`timescale 1ns/1ns

module accumulateUnit #(
  parameter int WordWidth = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  arithPkg::stepT       step,
  input  logic [WordWidth-1:0] regA,
  input  logic [WordWidth-1:0] regB,
  output logic [WordWidth-1:0] sum,
  output logic                 sumCarry,
  output logic                 carry
);

  localparam int Half = WordWidth / 2;

  logic [WordWidth-1:0] opX;
  logic [WordWidth-1:0] opY;
  logic                 carryIn;
  logic [WordWidth:0]   rawSum;

  ////////////////////////////////////////
  // Operand select
  ////////////////////////////////////////

  always_comb
  begin
    opX     = regB;
    opY     = regA;
    carryIn = 1'b0;
    case (step)
      arithPkg::stepSub:
      begin
        // Two's complement subtract
        opY     = ~regA;
        carryIn = 1'b1;
      end
      arithPkg::stepMul:
      begin
        // Partial product half plus multiplicand
        opX = {{Half{1'b0}}, regB[WordWidth-1:Half]};
        opY = {{Half{1'b0}}, regA[Half-1:0]};
      end
      default:
        carryIn = 1'b0;
    endcase
  end

  assign rawSum   = {1'b0, opX} + {1'b0, opY} + {{WordWidth{1'b0}}, carryIn};
  assign sum      = rawSum[WordWidth-1:0];
  // Bit just above the multiply half
  assign sumCarry = rawSum[Half];

  // Carry out on add, borrow on sub, cleared by multiply
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      carry <= 1'b0;
    else if (step == arithPkg::stepAdd)
      carry <= rawSum[WordWidth];
    else if (step == arithPkg::stepSub)
      carry <= ~rawSum[WordWidth];
    else if (step == arithPkg::stepMul)
      carry <= 1'b0;
  end

endmodule

//--- logic/arithUnit.sv
////////////////////////////////////////
// Arithmetic unit top level
////////////////////////////////////////

`timescale 1ns/1ns

module arithUnit #(
  parameter int WordWidth = 16
) (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           loadEn,
  input  arithPkg::byteSelT              byteSel,
  input  logic [arithPkg::ByteWidth-1:0] dataIn,
  input  logic                           opStart,
  input  arithPkg::opT                   op,
  input  arithPkg::byteSelT              readSel,
  output logic [arithPkg::ByteWidth-1:0] dataOut,
  output logic                           busy,
  output logic                           done,
  output logic                           carry
);

  arithPkg::stepT       step;
  logic [WordWidth-1:0] regA;
  logic [WordWidth-1:0] regB;
  logic [WordWidth-1:0] sum;
  logic                 sumCarry;

  // Control
  arithSequencer #(.WordWidth(WordWidth)) sequencer (
    .CLK     (CLK),
    .RST     (RST),
    .opStart (opStart),
    .op      (op),
    .step    (step),
    .busy    (busy),
    .done    (done)
  );

  // Operand storage
  operandRegs #(.WordWidth(WordWidth)) operands (
    .CLK      (CLK),
    .RST      (RST),
    .loadEn   (loadEn),
    .byteSel  (byteSel),
    .dataIn   (dataIn),
    .readSel  (readSel),
    .step     (step),
    .sum      (sum),
    .sumCarry (sumCarry),
    .busy     (busy),
    .regA     (regA),
    .regB     (regB),
    .dataOut  (dataOut)
  );

  // Shared adder
  accumulateUnit #(.WordWidth(WordWidth)) accumulate (
    .CLK      (CLK),
    .RST      (RST),
    .step     (step),
    .regA     (regA),
    .regB     (regB),
    .sum      (sum),
    .sumCarry (sumCarry),
    .carry    (carry)
  );

endmodule

//--- verif/arithUnit_assert.sv
////////////////////////////////////////
// Done and busy protocol assertions
////////////////////////////////////////

`timescale 1ns/1ns

module arithUnitAssert #(
  parameter int MulSteps = 8
) (
  input logic CLK,
  input logic RST,
  input logic busy,
  input logic done
);

  // Done is a single-cycle pulse
  assert property (@(posedge CLK) disable iff (!RST) done |=> !done)
    else $error("done stayed high for two cycles");

  assert property (@(posedge CLK) disable iff (!RST) !(done && busy))
    else $error("done and busy high in the same cycle");

  // Multiply holds busy for one cycle per step
  assert property (@(posedge CLK) disable iff (!RST) $rose(busy) |-> ##MulSteps $fell(busy))
    else $error("busy did not fall after the multiply steps");

endmodule

bind arithUnit arithUnitAssert assertChecks (
  .CLK  (CLK),
  .RST  (RST),
  .busy (busy),
  .done (done)
);

//--- verif/arithUnitTb.sv
////////////////////////////////////////
// Testbench for arithUnit
// Random loads, ops and readback against a model
////////////////////////////////////////

`timescale 1ns/1ns

module arithUnitTb;

  localparam int MulSteps      = 8;
  localparam int NumTrans      = 200;
  localparam int TimeoutCycles = NumTrans * 12 + 100;

  logic              CLK;
  logic              RST;
  logic              loadEn;
  arithPkg::byteSelT byteSel;
  logic [7:0]        dataIn;
  logic              opStart;
  arithPkg::opT      op;
  arithPkg::byteSelT readSel;
  logic [7:0]        dataOut;
  logic              busy;
  logic              done;
  logic              carry;

  // Reference model state
  logic [15:0] modelA;
  logic [15:0] modelB;
  logic        modelCarry;
  integer      seed;
  int          cycleCount = 0;

  arithUnit dut (.*);

  always #4 CLK = ~CLK;

  always @(posedge CLK)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= TimeoutCycles)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Some tests failed");
      $fatal(1, "Run stopped by cycle limit");
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic nextCycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic checkValue(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    if (expected !== actual)
    begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  function automatic logic [7:0] expectedByte(input logic [1:0] sel);
    case (sel)
      2'd0:    return modelA[7:0];
      2'd1:    return modelA[15:8];
      2'd2:    return modelB[7:0];
      default: return modelB[15:8];
    endcase
  endfunction

  task automatic readBackAll();
    for (int i = 0; i < 4; i++)
    begin
      readSel = arithPkg::byteSelT'(i[1:0]);
      @(negedge CLK);
      checkValue("dataOut", 16'(expectedByte(i[1:0])), 16'(dataOut));
      nextCycle();
    end
  endtask

  task automatic loadByte(input arithPkg::byteSelT sel, input logic [7:0] value);
    loadEn  = 1'b1;
    byteSel = sel;
    dataIn  = value;
    nextCycle();
    loadEn = 1'b0;
    case (sel)
      arithPkg::selALow:  modelA[7:0]  = value;
      arithPkg::selAHigh: modelA[15:8] = value;
      arithPkg::selBLow:  modelB[7:0]  = value;
      default:            modelB[15:8] = value;
    endcase
  endtask

  // ADD, SUB, or opLoad with opStart, which must do nothing
  task automatic runSingle(input arithPkg::opT code);
    logic [16:0] wide;
    logic        expectDone;
    wide       = {1'b0, modelB} + {1'b0, modelA};
    expectDone = 1'b1;
    if (code == arithPkg::opSub)
      wide = {(modelA > modelB), modelB - modelA};
    else if (code == arithPkg::opLoad)
    begin
      wide       = {modelCarry, modelB};
      expectDone = 1'b0;
    end
    opStart = 1'b1;
    op      = code;
    nextCycle();
    opStart = 1'b0;
    {modelCarry, modelB} = wide;
    @(negedge CLK);
    checkValue("done", 16'(expectDone), 16'(done));
    checkValue("busy", 16'd0, 16'(busy));
    checkValue("carry", 16'(modelCarry), 16'(carry));
    nextCycle();
  endtask

  // Random loads and op starts that the DUT must ignore while busy
  task automatic driveNoise(input logic enable);
    logic [31:0] rnd;
    rnd     = $random(seed);
    opStart = enable & rnd[0];
    op      = arithPkg::opT'(rnd[2:1]);
    loadEn  = enable & rnd[3];
    byteSel = arithPkg::byteSelT'(rnd[5:4]);
    dataIn  = rnd[13:6];
  endtask

  task automatic runMul();
    int   cycles;
    logic doneSeen;
    cycles   = 0;
    doneSeen = 1'b0;
    opStart  = 1'b1;
    op       = arithPkg::opMul;
    nextCycle();
    driveNoise(1'b1);
    modelB     = {8'd0, modelA[7:0]} * {8'd0, modelB[7:0]};
    modelCarry = 1'b0;
    @(negedge CLK);
    checkValue("busy", 16'd1, 16'(busy));
    // done rises on the last step edge
    while (!doneSeen && cycles < MulSteps + 2)
    begin
      nextCycle();
      cycles++;
      doneSeen = done;
      driveNoise(!doneSeen);
      @(negedge CLK);
      checkValue("busy", 16'(cycles < MulSteps), 16'(busy));
    end
    checkValue("done", 16'd1, 16'(doneSeen));
    checkValue("mulCycles", 16'(MulSteps), 16'(cycles));
    checkValue("carry", 16'd0, 16'(carry));
    nextCycle();
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    logic [31:0] rnd;
    seed    = 32'hbf8e;
    CLK     = 1'b0;
    RST     = 1'b0;
    loadEn  = 1'b0;
    byteSel = arithPkg::selALow;
    dataIn  = 8'd0;
    opStart = 1'b0;
    op      = arithPkg::opLoad;
    readSel = arithPkg::selALow;
    modelA     = 16'd0;
    modelB     = 16'd0;
    modelCarry = 1'b0;
    repeat (16) @(posedge CLK);
    #1;
    RST = 1'b1;
    @(negedge CLK);
    checkValue("busy", 16'd0, 16'(busy));
    checkValue("done", 16'd0, 16'(done));
    checkValue("carry", 16'd0, 16'(carry));
    nextCycle();
    readBackAll();
    for (int n = 0; n < NumTrans; n++)
    begin
      rnd = $random(seed);
      case (rnd[2:0])
        3'd3:    runSingle(arithPkg::opAdd);
        3'd4:    runSingle(arithPkg::opSub);
        3'd5:    runMul();
        3'd6:    readBackAll();
        3'd7:    runSingle(arithPkg::opLoad);
        default: loadByte(arithPkg::byteSelT'(rnd[4:3]), rnd[12:5]);
      endcase
      if (rnd[2:0] inside {3'd3, 3'd4, 3'd5, 3'd7})
        readBackAll();
    end
    $display("All tests passed");
    $finish;
  end

endmodule

//--- build.f
logic/arithPkg.sv
logic/arithSequencer.sv
logic/operandRegs.sv
logic/accumulateUnit.sv
logic/arithUnit.sv
verif/arithUnit_assert.sv
verif/arithUnitTb.sv

//--- run.sh
#!/bin/sh
# Build and run the arithUnit testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --assert --top-module arithUnitTb -f build.f -o simv \
  || { echo "Build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All tests passed" sim.log || { echo "Simulation FAILED"; exit 1; }
echo "Simulation PASSED"
